//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_lv_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/lv_core.sv
// lv_core: digital core of the gate driver LV die, SPI host access and HV link
`timescale 1ns/1ps
module lv_core import lv_pkg::*; #(
    parameter int OWT_BIT_CYC = 4,
    parameter int OWT_TMO_CYC = 64
)(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_spi_sclk,
    input  logic      i_spi_csb,
    input  logic      i_spi_mosi,
    output logic      o_spi_miso,
    output logic      o_lv_hv_owt_tx,
    input  logic      i_hv_lv_owt_rx,
    output logic      o_pwm_en,
    output logic      o_intb_n,
    output reg_data_t o_ana_trim
);

    // ============================================================
    // interconnect
    // ============================================================
    reg_req_t   spi_req;
    logic       spi_req_valid;
    logic       spi_req_ready;
    reg_rsp_t   spi_rsp;
    logic       spi_rsp_valid;
    logic       spi_err;
    reg_req_t   reg_req;
    logic       reg_req_valid;
    reg_rsp_t   reg_rsp;
    reg_req_t   owt_req;
    logic       owt_req_valid;
    logic       owt_req_ready;
    reg_rsp_t   owt_rsp;
    logic       owt_rsp_valid;
    logic       com_err_pulse;
    logic       tmo_err_pulse;
    logic       tmo_en;
    lv_mode_t   mode_cmd;
    logic       mode_wr;
    lv_status_t status;
    ctrl_st_e   cur_st;

    lv_spi_slv u_spi_slv (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_spi_sclk  (i_spi_sclk),
        .i_spi_csb   (i_spi_csb),
        .i_spi_mosi  (i_spi_mosi),
        .o_spi_miso  (o_spi_miso),
        .o_req       (spi_req),
        .o_req_valid (spi_req_valid),
        .i_req_ready (spi_req_ready),
        .i_rsp       (spi_rsp),
        .i_rsp_valid (spi_rsp_valid),
        .o_spi_err   (spi_err)
    );

    lv_reg_access_ctrl u_reg_access_ctrl (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_spi_req       (spi_req),
        .i_spi_req_valid (spi_req_valid),
        .o_spi_req_ready (spi_req_ready),
        .o_spi_rsp       (spi_rsp),
        .o_spi_rsp_valid (spi_rsp_valid),
        .o_reg_req       (reg_req),
        .o_reg_req_valid (reg_req_valid),
        .i_reg_rsp       (reg_rsp),
        .o_owt_req       (owt_req),
        .o_owt_req_valid (owt_req_valid),
        .i_owt_req_ready (owt_req_ready),
        .i_owt_rsp       (owt_rsp),
        .i_owt_rsp_valid (owt_rsp_valid)
    );

    lv_owt_ctrl #(
        .OWT_BIT_CYC (OWT_BIT_CYC),
        .OWT_TMO_CYC (OWT_TMO_CYC)
    ) u_owt_ctrl (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_req          (owt_req),
        .i_req_valid    (owt_req_valid),
        .o_req_ready    (owt_req_ready),
        .o_rsp          (owt_rsp),
        .o_rsp_valid    (owt_rsp_valid),
        .o_lv_hv_owt_tx (o_lv_hv_owt_tx),
        .i_hv_lv_owt_rx (i_hv_lv_owt_rx),
        .i_tmo_en       (tmo_en),
        .o_com_err      (com_err_pulse),
        .o_tmo_err      (tmo_err_pulse)
    );

    lv_reg_slv u_reg_slv (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (reg_req),
        .i_req_valid (reg_req_valid),
        .o_rsp       (reg_rsp),
        .i_cur_st    (cur_st),
        .i_spi_err   (spi_err),
        .i_com_err   (com_err_pulse),
        .i_tmo_err   (tmo_err_pulse),
        .o_status    (status),
        .o_mode_cmd  (mode_cmd),
        .o_mode_wr   (mode_wr),
        .o_tmo_en    (tmo_en),
        .o_ana_trim  (o_ana_trim)
    );

    lv_ctrl_unit u_ctrl_unit (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_mode_cmd (mode_cmd),
        .i_mode_wr  (mode_wr),
        .i_status   (status),
        .o_cur_st   (cur_st),
        .o_pwm_en   (o_pwm_en),
        .o_intb_n   (o_intb_n)
    );

endmodule

//--- hdl/lv_ctrl_unit.sv
// lv_ctrl_unit: operating mode FSM, gates PWM enable and drives the interrupt pin
`timescale 1ns/1ps
module lv_ctrl_unit import lv_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  lv_mode_t   i_mode_cmd,
    input  logic       i_mode_wr,
    input  lv_status_t i_status,
    output ctrl_st_e   o_cur_st,
    output logic       o_pwm_en,
    output logic       o_intb_n
);

    logic any_err;

    assign any_err  = (i_status != '0);
    assign o_pwm_en = (o_cur_st == ST_NORMAL);
    assign o_intb_n = (o_cur_st != ST_FAULT);   // active low

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cur_st <= ST_WAIT;
        end else if (i_mode_wr && i_mode_cmd.reset_en) begin
            o_cur_st <= ST_WAIT;   // from any state
        end else begin
            case (o_cur_st)
                ST_WAIT: begin
                    if (i_mode_wr && i_mode_cmd.cfg_en) begin
                        o_cur_st <= ST_CFG;
                    end
                end
                ST_CFG: begin
                    if (i_mode_wr && i_mode_cmd.normal_en && !any_err) begin
                        o_cur_st <= ST_NORMAL;
                    end
                end
                ST_NORMAL: begin
                    if (any_err) begin
                        o_cur_st <= ST_FAULT;
                    end
                end
                default: o_cur_st <= ST_FAULT;  // FAULT holds until reset_en
            endcase
        end
    end

endmodule

//--- hdl/lv_owt_ctrl.sv
// OWT controller that sends register frames to the HV die and receives its responses
`timescale 1ns/1ps
module lv_owt_ctrl import lv_pkg::*; #(
    parameter int OWT_BIT_CYC = 4,
    parameter int OWT_TMO_CYC = 64
)(
    input  logic     i_clk,
    input  logic     i_reset,
    input  reg_req_t i_req,
    input  logic     i_req_valid,
    output logic     o_req_ready,
    output reg_rsp_t o_rsp,
    output logic     o_rsp_valid,
    output logic     o_lv_hv_owt_tx,
    input  logic     i_hv_lv_owt_rx,
    input  logic     i_tmo_en,
    output logic     o_com_err,
    output logic     o_tmo_err
);

    localparam int CYC_W   = (OWT_BIT_CYC > 1) ? $clog2(OWT_BIT_CYC) : 1;
    localparam int TMO_W   = $clog2(OWT_TMO_CYC + 1);
    localparam int TX_BITS = 18;  // start, wr, addr, data, parity, stop
    localparam int RX_BITS = 11;  // start, data, parity, stop

    typedef enum logic [1:0] {
        OWT_IDLE,
        OWT_TX,
        OWT_WAIT,
        OWT_RX
    } owt_st_e;

    owt_st_e            state;
    logic [CYC_W-1:0]   cyc_cnt;
    logic [4:0]         bit_idx;
    logic [TMO_W-1:0]   tmo_cnt;
    logic               bit_end;
    logic               mid_bit;
    owt_addr_t          tx_addr;
    logic [14:0]        tx_payload;
    logic [TX_BITS-1:0] tx_shift;
    logic [1:0]         rx_sync;
    logic [RX_BITS-2:0] rx_shift;
    logic [RX_BITS-1:0] rx_frame;
    logic               rx_bad;

    assign o_req_ready    = (state == OWT_IDLE);
    assign o_lv_hv_owt_tx = tx_shift[TX_BITS-1];
    assign tx_addr        = i_req.addr[5:0];
    assign tx_payload     = {i_req.wr, tx_addr, i_req.wdata};
    assign bit_end        = (cyc_cnt == CYC_W'(OWT_BIT_CYC - 1));
    // start detection already costs one cycle of the bit
    assign mid_bit        = (cyc_cnt == CYC_W'(OWT_BIT_CYC / 2 - 1));
    assign rx_frame       = {rx_shift, rx_sync[1]};
    assign rx_bad         = (^rx_frame[9:1]) | ~rx_frame[0];  // even parity and stop high

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_hv_lv_owt_rx};
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == OWT_RX && mid_bit) begin
            rx_shift <= {rx_shift[RX_BITS-3:0], rx_sync[1]};
        end
    end

    // ============================================================
    // link sequencing
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= OWT_IDLE;
            tx_shift    <= '1;   // line idles high
            cyc_cnt     <= '0;
            bit_idx     <= '0;
            tmo_cnt     <= '0;
            o_rsp       <= '0;
            o_rsp_valid <= 1'b0;
            o_com_err   <= 1'b0;
            o_tmo_err   <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            o_com_err   <= 1'b0;
            o_tmo_err   <= 1'b0;
            cyc_cnt     <= bit_end ? '0 : cyc_cnt + 1'b1;
            case (state)
                OWT_IDLE: begin
                    cyc_cnt <= '0;
                    bit_idx <= '0;
                    if (i_req_valid) begin
                        tx_shift   <= {1'b0, tx_payload, ^tx_payload, 1'b1};
                        o_rsp.addr <= i_req.addr;
                        state      <= OWT_TX;
                    end
                end
                OWT_TX: begin
                    if (bit_end) begin
                        tx_shift <= {tx_shift[TX_BITS-2:0], 1'b1};
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 5'(TX_BITS - 1)) begin
                            tmo_cnt <= '0;
                            state   <= OWT_WAIT;
                        end
                    end
                end
                OWT_WAIT: begin
                    cyc_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync[1]) begin
                        state <= OWT_RX;   // start bit seen
                    end else if (i_tmo_en) begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                        if (tmo_cnt == TMO_W'(OWT_TMO_CYC - 1)) begin
                            o_rsp.err   <= 1'b1;
                            o_rsp.rdata <= '0;
                            o_rsp_valid <= 1'b1;
                            o_tmo_err   <= 1'b1;
                            state       <= OWT_IDLE;
                        end
                    end
                end
                OWT_RX: begin
                    if (mid_bit) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 5'(RX_BITS - 1)) begin
                            o_rsp.err   <= rx_bad;
                            o_rsp.rdata <= rx_bad ? '0 : rx_frame[9:2];
                            o_rsp_valid <= 1'b1;
                            o_com_err   <= rx_bad;
                            state       <= OWT_IDLE;
                        end
                    end
                end
                default: state <= OWT_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/lv_pkg.sv
// lv_pkg: shared widths, register map, frame layouts and control states of the LV die core
package lv_pkg;

    // ============================================================
    // widths and register map
    // ============================================================
    localparam int SPI_FRAME_W = 16;

    typedef logic [6:0] reg_addr_t;   // bit 6 set selects the HV die
    typedef logic [7:0] reg_data_t;
    typedef logic [5:0] owt_addr_t;   // address field of an OWT frame

    localparam reg_addr_t ADDR_MODE     = 7'h00;
    localparam reg_addr_t ADDR_COM_CFG  = 7'h01;  // bit 0 enables the OWT timeout
    localparam reg_addr_t ADDR_STATUS1  = 7'h02;  // sticky, write 1 to clear
    localparam reg_addr_t ADDR_STATUS2  = 7'h03;  // current control state
    localparam reg_addr_t ADDR_ANA_TRIM = 7'h04;

    // ============================================================
    // frames, same bit order as on the SPI pins
    // ============================================================
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic      err;
        reg_addr_t addr;
        reg_data_t rdata;
    } reg_rsp_t;

    // STATUS1 bits 3..0
    typedef struct packed {
        logic cfg_err;      // config write refused outside CFG
        logic owt_tmo_err;
        logic owt_com_err;
        logic spi_err;
    } lv_status_t;

    // MODE bits 2..0
    typedef struct packed {
        logic reset_en;
        logic normal_en;
        logic cfg_en;
    } lv_mode_t;

    typedef enum logic [1:0] {
        ST_WAIT   = 2'd0,
        ST_CFG    = 2'd1,
        ST_NORMAL = 2'd2,
        ST_FAULT  = 2'd3
    } ctrl_st_e;

endpackage

//--- hdl/lv_reg_access_ctrl.sv
// lv_reg_access_ctrl: routes each SPI request to the local registers or over OWT
`timescale 1ns/1ps
module lv_reg_access_ctrl import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  reg_req_t i_spi_req,
    input  logic     i_spi_req_valid,
    output logic     o_spi_req_ready,
    output reg_rsp_t o_spi_rsp,
    output logic     o_spi_rsp_valid,
    output reg_req_t o_reg_req,
    output logic     o_reg_req_valid,
    input  reg_rsp_t i_reg_rsp,
    output reg_req_t o_owt_req,
    output logic     o_owt_req_valid,
    input  logic     i_owt_req_ready,
    input  reg_rsp_t i_owt_rsp,
    input  logic     i_owt_rsp_valid
);

    typedef enum logic [1:0] {
        RAC_IDLE,
        RAC_LOCAL,
        RAC_REMOTE
    } rac_st_e;

    rac_st_e  state;
    reg_req_t req_q;

    assign o_spi_req_ready = (state == RAC_IDLE);  // one transaction in flight
    assign o_reg_req       = req_q;
    assign o_owt_req       = req_q;

    always_ff @(posedge i_clk) begin
        if (o_spi_req_ready && i_spi_req_valid) begin
            req_q <= i_spi_req;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state           <= RAC_IDLE;
            o_reg_req_valid <= 1'b0;
            o_owt_req_valid <= 1'b0;
            o_spi_rsp_valid <= 1'b0;
            o_spi_rsp       <= '0;
        end else begin
            o_reg_req_valid <= 1'b0;
            o_spi_rsp_valid <= 1'b0;
            case (state)
                RAC_IDLE: begin
                    if (i_spi_req_valid) begin
                        if (i_spi_req.addr[6]) begin  // HV die register
                            o_owt_req_valid <= 1'b1;
                            state           <= RAC_REMOTE;
                        end else begin
                            o_reg_req_valid <= 1'b1;
                            state           <= RAC_LOCAL;
                        end
                    end
                end
                RAC_LOCAL: begin
                    // register file answers the cycle after the strobe
                    if (!o_reg_req_valid) begin
                        o_spi_rsp       <= i_reg_rsp;
                        o_spi_rsp_valid <= 1'b1;
                        state           <= RAC_IDLE;
                    end
                end
                RAC_REMOTE: begin
                    if (i_owt_req_ready) begin
                        o_owt_req_valid <= 1'b0;
                    end
                    if (i_owt_rsp_valid) begin
                        o_spi_rsp       <= i_owt_rsp;
                        o_spi_rsp_valid <= 1'b1;
                        state           <= RAC_IDLE;
                    end
                end
                default: state <= RAC_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/lv_reg_slv.sv
// lv_reg_slv: local register file with config write protection and sticky status
`timescale 1ns/1ps
module lv_reg_slv import lv_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,
    input  reg_req_t   i_req,
    input  logic       i_req_valid,
    output reg_rsp_t   o_rsp,
    input  ctrl_st_e   i_cur_st,
    input  logic       i_spi_err,
    input  logic       i_com_err,
    input  logic       i_tmo_err,
    output lv_status_t o_status,
    output lv_mode_t   o_mode_cmd,
    output logic       o_mode_wr,
    output logic       o_tmo_en,
    output reg_data_t  o_ana_trim
);

    reg_data_t  com_cfg;
    reg_data_t  rdata;
    lv_status_t err_set;
    logic       wr_en;
    logic       cfg_open;
    logic       cfg_wr;   // write aimed at a protected register

    assign wr_en    = i_req_valid & i_req.wr;
    assign cfg_open = (i_cur_st == ST_CFG);
    assign cfg_wr   = wr_en & ((i_req.addr == ADDR_COM_CFG) | (i_req.addr == ADDR_ANA_TRIM));
    assign o_tmo_en = com_cfg[0];

    assign err_set.cfg_err     = cfg_wr & ~cfg_open;
    assign err_set.owt_tmo_err = i_tmo_err;
    assign err_set.owt_com_err = i_com_err;
    assign err_set.spi_err     = i_spi_err;

    always_comb begin
        case (i_req.addr)
            ADDR_MODE:     rdata = {5'b0, o_mode_cmd};
            ADDR_COM_CFG:  rdata = com_cfg;
            ADDR_STATUS1:  rdata = {4'b0, o_status};
            ADDR_STATUS2:  rdata = {6'b0, i_cur_st};
            ADDR_ANA_TRIM: rdata = o_ana_trim;
            default:       rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_mode_cmd <= '0;
            o_mode_wr  <= 1'b0;
            com_cfg    <= '0;
            o_ana_trim <= '0;
            o_status   <= '0;
        end else begin
            o_mode_wr <= wr_en && (i_req.addr == ADDR_MODE);
            if (wr_en && i_req.addr == ADDR_MODE) begin
                o_mode_cmd <= lv_mode_t'(i_req.wdata[2:0]);
            end
            if (cfg_wr && cfg_open && i_req.addr == ADDR_COM_CFG) begin
                com_cfg <= i_req.wdata;
            end
            if (cfg_wr && cfg_open && i_req.addr == ADDR_ANA_TRIM) begin
                o_ana_trim <= i_req.wdata;
            end
            // new flags win over a clear in the same cycle
            if (wr_en && i_req.addr == ADDR_STATUS1) begin
                o_status <= (o_status & ~lv_status_t'(i_req.wdata[3:0])) | err_set;
            end else begin
                o_status <= o_status | err_set;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_rsp.err   <= 1'b0;
            o_rsp.addr  <= i_req.addr;
            o_rsp.rdata <= rdata;   // value before the write
        end
    end

endmodule

//--- hdl/lv_spi_slv.sv
// lv_spi_slv: mode 0 SPI slave oversampled on the core clock, frames to register requests
`timescale 1ns/1ps
module lv_spi_slv import lv_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_spi_sclk,
    input  logic     i_spi_csb,
    input  logic     i_spi_mosi,
    output logic     o_spi_miso,
    output reg_req_t o_req,
    output logic     o_req_valid,
    input  logic     i_req_ready,
    input  reg_rsp_t i_rsp,
    input  logic     i_rsp_valid,
    output logic     o_spi_err
);

    localparam int CNT_W = $clog2(SPI_FRAME_W) + 1;

    logic [2:0]             sclk_q;     // 2 sync stages + edge detect
    logic [2:0]             csb_q;
    logic [1:0]             mosi_q;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   csb_rise;
    logic                   csb_fall;
    logic                   active;
    logic [CNT_W-1:0]       bit_cnt;
    logic [SPI_FRAME_W-1:0] shift_in;
    logic [SPI_FRAME_W-1:0] shift_out;
    reg_rsp_t               rsp_hold;   // last finished transaction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sclk_q <= '0;
            csb_q  <= '1;
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], i_spi_sclk};
            csb_q  <= {csb_q[1:0], i_spi_csb};
            mosi_q <= {mosi_q[0], i_spi_mosi};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign csb_rise  = csb_q[1] & ~csb_q[2];
    assign csb_fall  = ~csb_q[1] & csb_q[2];
    assign active    = ~csb_q[1];

    // mosi in on rising sclk, count saturates so long frames stay bad
    always_ff @(posedge i_clk) begin
        if (active && sclk_rise) begin
            shift_in <= {shift_in[SPI_FRAME_W-2:0], mosi_q[1]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || csb_fall) begin
            bit_cnt <= '0;
        end else if (active && sclk_rise && bit_cnt != '1) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_req_valid <= 1'b0;
            o_spi_err   <= 1'b0;
        end else begin
            o_spi_err <= 1'b0;
            if (o_req_valid && i_req_ready) begin
                o_req_valid <= 1'b0;
            end
            if (csb_rise) begin
                if (bit_cnt == CNT_W'(SPI_FRAME_W) && i_req_ready && !o_req_valid) begin
                    o_req_valid <= 1'b1;
                end else begin
                    o_spi_err <= 1'b1;  // wrong length or busy
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (csb_rise && !o_req_valid) begin
            o_req <= shift_in;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rsp_hold <= '0;
        end else if (i_rsp_valid) begin
            rsp_hold <= i_rsp;
        end
    end

    // miso out, first bit ready as soon as csb falls
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            shift_out <= '0;
        end else if (csb_fall) begin
            shift_out <= rsp_hold;
        end else if (active && sclk_fall) begin
            shift_out <= {shift_out[SPI_FRAME_W-2:0], 1'b0};
        end
    end

    assign o_spi_miso = shift_out[SPI_FRAME_W-1];

endmodule

//--- sources.f
hdl/lv_pkg.sv
hdl/lv_spi_slv.sv
hdl/lv_reg_access_ctrl.sv
hdl/lv_owt_ctrl.sv
hdl/lv_reg_slv.sv
hdl/lv_ctrl_unit.sv
hdl/lv_core.sv
verif/lv_core_checker.sv
verif/tb_lv_core.sv

//--- verif/lv_core_checker.sv
// checker that compares SPI response words and output pins of the LV core with expected values
`timescale 1ns/1ps
module lv_core_checker import lv_pkg::*; (
    input  logic      i_clk,
    input  logic      i_spi_sclk,
    input  logic      i_spi_csb,
    input  logic      i_spi_miso,
    input  logic      i_owt_tx,
    input  logic      i_pwm_en,
    input  logic      i_intb_n,
    input  reg_data_t i_ana_trim,
    input  logic      i_check,
    input  int        i_test_idx,
    input  reg_rsp_t  i_exp_rsp,
    input  logic      i_exp_pwm,
    input  logic      i_exp_intb,
    input  reg_data_t i_exp_trim,
    output int        o_pass_cnt,
    output int        o_fail_cnt
);

    logic [SPI_FRAME_W-1:0] miso_shift;
    logic [SPI_FRAME_W-1:0] miso_word;   // last complete frame on miso
    logic                   match;
    int                     pass_cnt = 0;
    int                     fail_cnt = 0;

    assign o_pass_cnt = pass_cnt;
    assign o_fail_cnt = fail_cnt;

    // host samples miso on rising sclk in mode 0
    always @(posedge i_spi_sclk) begin
        if (!i_spi_csb) begin
            miso_shift <= {miso_shift[SPI_FRAME_W-2:0], i_spi_miso};
        end
    end

    always @(posedge i_spi_csb) begin
        miso_word <= miso_shift;
    end

    // pins settle by the falling clock edge
    always @(negedge i_clk) begin
        if (i_check) begin
            match = (miso_word === i_exp_rsp) && (i_pwm_en === i_exp_pwm)
                && (i_intb_n === i_exp_intb) && (i_ana_trim === i_exp_trim)
                && (i_owt_tx === 1'b1);   // link idle between frames
            if (match) begin
                pass_cnt++;
                $display("test %0d ok, rsp %h", i_test_idx, miso_word);
            end else begin
                fail_cnt++;
                $display("mismatch at %0t: test %0d rsp %h exp %h pwm %b exp %b %s",
                         $time, i_test_idx, miso_word, i_exp_rsp, i_pwm_en, i_exp_pwm,
                         $sformatf("intb %b exp %b trim %h exp %h tx %b", i_intb_n,
                                   i_exp_intb, i_ana_trim, i_exp_trim, i_owt_tx));
            end
        end
    end

endmodule

//--- verif/tb_lv_core.sv
// testbench for the LV die core with SPI host driver, HV die OWT model and test table
`timescale 1ns/1ps
module tb_lv_core import lv_pkg::*; ();

    localparam int  CLK_PER      = 40;
    localparam time DRV_DLY      = 2;
    localparam int  RST_CYC      = 5;
    localparam int  SCLK_HALF    = 4;     // core clocks per sclk phase
    localparam int  OWT_BIT_CYC  = 4;
    localparam int  HV_TURN_CYC  = 4;     // HV turnaround before answering
    localparam int  GAP_CYC      = 200;
    localparam int  OWT_WAIT_MAX = 40;

    typedef enum logic [1:0] {
        HV_NONE,
        HV_ACK,
        HV_BADPAR,
        HV_SILENT
    } hv_mode_e;

    typedef struct packed {
        reg_req_t  frame;
        hv_mode_e  hv;
        reg_rsp_t  rsp;
        logic      pwm;
        logic      intb;
        reg_data_t trim;
    } test_row_t;

    localparam reg_req_t NOP_READ = {1'b0, ADDR_STATUS1, 8'h00};

    logic      clk;
    logic      reset;
    logic      spi_sclk;
    logic      spi_csb;
    logic      spi_mosi;
    logic      spi_miso;
    logic      owt_tx;
    logic      owt_rx;
    logic      pwm_en;
    logic      intb_n;
    reg_data_t ana_trim;
    test_row_t tbl[$];
    test_row_t cur_row;
    reg_data_t hv_mem [64];
    integer    seed;
    int        tb_errs = 0;
    int        pass_cnt;
    int        fail_cnt;
    logic      check;
    int        test_idx;

    lv_core u_dut (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_spi_sclk     (spi_sclk),
        .i_spi_csb      (spi_csb),
        .i_spi_mosi     (spi_mosi),
        .o_spi_miso     (spi_miso),
        .o_lv_hv_owt_tx (owt_tx),
        .i_hv_lv_owt_rx (owt_rx),
        .o_pwm_en       (pwm_en),
        .o_intb_n       (intb_n),
        .o_ana_trim     (ana_trim)
    );

    lv_core_checker u_chk (
        .i_clk      (clk),
        .i_spi_sclk (spi_sclk),
        .i_spi_csb  (spi_csb),
        .i_spi_miso (spi_miso),
        .i_owt_tx   (owt_tx),
        .i_pwm_en   (pwm_en),
        .i_intb_n   (intb_n),
        .i_ana_trim (ana_trim),
        .i_check    (check),
        .i_test_idx (test_idx),
        .i_exp_rsp  (cur_row.rsp),
        .i_exp_pwm  (cur_row.pwm),
        .i_exp_intb (cur_row.intb),
        .i_exp_trim (cur_row.trim),
        .o_pass_cnt (pass_cnt),
        .o_fail_cnt (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic add_row(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                           input hv_mode_e hv, input logic err, input reg_data_t rdata,
                           input logic pwm, input logic intb, input reg_data_t trim);
        test_row_t row;
        row.frame = {wr, addr, wdata};
        row.hv    = hv;
        row.rsp   = {err, addr, rdata};   // response carries the request address
        row.pwm   = pwm;
        row.intb  = intb;
        row.trim  = trim;
        tbl.push_back(row);
    endtask

    // ============================================================
    // SPI host and HV die model
    // ============================================================
    task automatic spi_frame(input reg_req_t frame);
        spi_csb = 1'b0;
        step(SCLK_HALF);
        for (int b = SPI_FRAME_W - 1; b >= 0; b--) begin
            spi_mosi = frame[b];
            step(SCLK_HALF);
            spi_sclk = 1'b1;
            step(SCLK_HALF);
            spi_sclk = 1'b0;
        end
        step(SCLK_HALF);
        spi_csb  = 1'b1;
        spi_mosi = 1'b0;
    endtask

    task automatic serve_owt(input hv_mode_e mode, input reg_req_t exp_frame);
        logic [16:0] bits;      // wr, addr, data, parity, stop
        logic [14:0] payload;
        logic [16:0] exp_bits;
        logic [10:0] rsp_bits;
        int          waited;
        owt_addr_t   addr;
        reg_data_t   data;
        payload  = {exp_frame.wr, exp_frame.addr[5:0], exp_frame.wdata};
        exp_bits = {payload, ^payload, 1'b1};   // even parity and stop bit
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (owt_tx !== 1'b0 && waited < OWT_WAIT_MAX);
        if (owt_tx !== 1'b0) begin
            $display("timeout: the LV die sent no OWT frame within %0d cycles", OWT_WAIT_MAX);
            tb_errs++;
        end else begin
            repeat (OWT_BIT_CYC / 2) @(negedge clk);   // middle of start bit
            for (int k = 16; k >= 0; k--) begin
                repeat (OWT_BIT_CYC) @(negedge clk);
                bits[k] = owt_tx;
            end
            if (bits !== exp_bits) begin
                $display("mismatch at %0t: OWT frame %h from the LV die, expected %h",
                         $time, bits, exp_bits);
                tb_errs++;
            end
            addr = bits[15:10];
            if (bits[16]) begin
                hv_mem[addr] = bits[9:2];
            end
            data     = hv_mem[addr];   // content after the access
            rsp_bits = {1'b0, data, (^data) ^ (mode == HV_BADPAR), 1'b1};
            if (mode != HV_SILENT) begin
                step(HV_TURN_CYC);
                for (int k = 10; k >= 0; k--) begin
                    owt_rx = rsp_bits[k];
                    step(OWT_BIT_CYC);
                end
            end
        end
    endtask

    // row frame, timed gap, then a status read that returns the row response
    task automatic run_row(input int idx);
        cur_row = tbl[idx];
        spi_frame(cur_row.frame);
        fork
            step(GAP_CYC);
            if (cur_row.hv != HV_NONE) serve_owt(cur_row.hv, cur_row.frame);
        join
        spi_frame(NOP_READ);
        step(8);
        test_idx = idx;
        check    = 1'b1;
        step(1);
        check    = 1'b0;
    endtask

    task automatic build_table();
        reg_addr_t ra;
        reg_addr_t ra2;
        reg_data_t rd;
        int        rnd;
        rnd = $random(seed);
        ra  = {1'b1, rnd[5:0]};
        rd  = rnd[15:8];
        rnd = $random(seed);
        ra2 = {1'b1, rnd[5:0]};
        //      wr    addr           wdata  hv         err   rdata  pwm   intb  trim
        add_row(1'b0, ADDR_STATUS2,  8'h00, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'h00);
        add_row(1'b1, ADDR_ANA_TRIM, 8'h5C, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'h00);
        add_row(1'b0, ADDR_STATUS1,  8'h00, HV_NONE,   1'b0, 8'h08, 1'b0, 1'b1, 8'h00);
        add_row(1'b1, ADDR_MODE,     8'h01, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'h00);
        add_row(1'b1, ADDR_STATUS1,  8'h0F, HV_NONE,   1'b0, 8'h08, 1'b0, 1'b1, 8'h00);
        add_row(1'b1, ADDR_ANA_TRIM, 8'hA7, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ADDR_ANA_TRIM, 8'h00, HV_NONE,   1'b0, 8'hA7, 1'b0, 1'b1, 8'hA7);
        add_row(1'b1, ADDR_COM_CFG,  8'h01, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'hA7);
        add_row(1'b1, ra,            rd,    HV_ACK,    1'b0, rd,    1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ra,            8'h00, HV_ACK,    1'b0, rd,    1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ra,            8'h00, HV_BADPAR, 1'b1, 8'h00, 1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ADDR_STATUS1,  8'h00, HV_NONE,   1'b0, 8'h02, 1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ra2,           8'h00, HV_SILENT, 1'b1, 8'h00, 1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ADDR_STATUS1,  8'h00, HV_NONE,   1'b0, 8'h06, 1'b0, 1'b1, 8'hA7);
        add_row(1'b1, ADDR_STATUS1,  8'h0F, HV_NONE,   1'b0, 8'h06, 1'b0, 1'b1, 8'hA7);
        add_row(1'b1, ADDR_MODE,     8'h02, HV_NONE,   1'b0, 8'h01, 1'b1, 1'b1, 8'hA7);
        add_row(1'b1, ADDR_ANA_TRIM, 8'h33, HV_NONE,   1'b0, 8'hA7, 1'b0, 1'b0, 8'hA7);
        add_row(1'b0, ADDR_STATUS2,  8'h00, HV_NONE,   1'b0, 8'h03, 1'b0, 1'b0, 8'hA7);
        add_row(1'b1, ADDR_MODE,     8'h04, HV_NONE,   1'b0, 8'h02, 1'b0, 1'b1, 8'hA7);
        add_row(1'b0, ADDR_STATUS2,  8'h00, HV_NONE,   1'b0, 8'h00, 1'b0, 1'b1, 8'hA7);
    endtask

    initial begin
        seed     = 76871;
        reset    = 1'b1;
        spi_sclk = 1'b0;
        spi_csb  = 1'b1;
        spi_mosi = 1'b0;
        owt_rx   = 1'b1;   // link idles high
        check    = 1'b0;
        test_idx = 0;
        cur_row  = '0;
        for (int i = 0; i < 64; i++) begin
            hv_mem[i] = 8'(i * 37) ^ 8'h5A;
        end
        build_table();
        step(RST_CYC);
        reset = 1'b0;
        step(4);
        foreach (tbl[i]) begin
            run_row(i);
        end
        step(4);
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 tbl.size(), pass_cnt, fail_cnt, tb_errs);
        if (fail_cnt == 0 && tb_errs == 0 && pass_cnt == tbl.size()) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
